// ==== include/fm_detune_table.svh ====
`ifndef FM_DETUNE_TABLE_SVH
`define FM_DETUNE_TABLE_SVH

// Detune offsets, 32 key codes by amounts 0 to 3
// Amount 0 is always zero
`define FM_DETUNE_TABLE '{ \
	'{5'd0, 5'd0, 5'd1, 5'd2}, \
	'{5'd0, 5'd0, 5'd1, 5'd2}, \
	'{5'd0, 5'd0, 5'd1, 5'd2}, \
	'{5'd0, 5'd0, 5'd1, 5'd2}, \
	'{5'd0, 5'd1, 5'd2, 5'd2}, \
	'{5'd0, 5'd1, 5'd2, 5'd3}, \
	'{5'd0, 5'd1, 5'd2, 5'd3}, \
	'{5'd0, 5'd1, 5'd2, 5'd3}, \
	'{5'd0, 5'd1, 5'd2, 5'd4}, \
	'{5'd0, 5'd1, 5'd3, 5'd4}, \
	'{5'd0, 5'd1, 5'd3, 5'd4}, \
	'{5'd0, 5'd1, 5'd3, 5'd5}, \
	'{5'd0, 5'd2, 5'd4, 5'd5}, \
	'{5'd0, 5'd2, 5'd4, 5'd6}, \
	'{5'd0, 5'd2, 5'd4, 5'd6}, \
	'{5'd0, 5'd2, 5'd5, 5'd7}, \
	'{5'd0, 5'd2, 5'd5, 5'd8}, \
	'{5'd0, 5'd3, 5'd6, 5'd8}, \
	'{5'd0, 5'd3, 5'd6, 5'd9}, \
	'{5'd0, 5'd3, 5'd7, 5'd10}, \
	'{5'd0, 5'd4, 5'd8, 5'd11}, \
	'{5'd0, 5'd4, 5'd8, 5'd12}, \
	'{5'd0, 5'd4, 5'd9, 5'd13}, \
	'{5'd0, 5'd5, 5'd10, 5'd14}, \
	'{5'd0, 5'd5, 5'd11, 5'd16}, \
	'{5'd0, 5'd6, 5'd12, 5'd17}, \
	'{5'd0, 5'd6, 5'd13, 5'd19}, \
	'{5'd0, 5'd7, 5'd14, 5'd20}, \
	'{5'd0, 5'd8, 5'd16, 5'd22}, \
	'{5'd0, 5'd8, 5'd16, 5'd22}, \
	'{5'd0, 5'd8, 5'd16, 5'd22}, \
	'{5'd0, 5'd8, 5'd16, 5'd22} \
}

`endif

// ==== design/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

	// Register write opcodes
	typedef enum logic [2:0] {
		// fnum bits 10..8 and block, held in a staging latch
		OP_FNUM_HI = 3'd0,
		// fnum bits 7..0, commits the staged high part
		OP_FNUM_LO = 3'd1,
		// Detune in bits 6..4, multiple in bits 3..0
		OP_DT_MUL  = 3'd2,
		// Global test register, bit 3 disables accumulation
		OP_TEST    = 3'd3,
		// Restart the phase of one slot
		OP_KEY_ON  = 3'd4
	} pg_op_e;

	// Field widths
	localparam int FNUM_W  = 11;
	localparam int BLOCK_W = 3;
	localparam int DT_W    = 3;
	localparam int MUL_W   = 4;
	localparam int DTVAL_W = 5;

	// Phase accumulator and output widths
	localparam int PHASE_W = 20;
	localparam int OUT_W   = 10;

endpackage

`default_nettype wire

// ==== design/fm_pg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_pg_regs
	import fm_pkg::*;
	#(
	parameter int NUM_SLOTS = 24,
	localparam int SLOT_W = $clog2(NUM_SLOTS)
	)
	(
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  logic               wr_i,
	input  pg_op_e             wr_op_i,
	input  logic [SLOT_W-1:0]  wr_slot_i,
	input  logic [7:0]         wr_data_i,
	output logic [SLOT_W-1:0]  slot_o,
	output logic [FNUM_W-1:0]  fnum_o,
	output logic [BLOCK_W-1:0] block_o,
	output logic [DT_W-1:0]    dt_o,
	output logic [MUL_W-1:0]   multi_o,
	output logic               key_on_o,
	output logic               acc_dis_o
	);

	logic [SLOT_W-1:0]   slot_cnt;
	logic                wr_ok;

	logic [FNUM_W-9:0]   fnum_hi_stage;
	logic [BLOCK_W-1:0]  block_stage;
	logic                acc_dis_r;

	logic [FNUM_W-1:0]   fnum_r  [NUM_SLOTS];
	logic [BLOCK_W-1:0]  block_r [NUM_SLOTS];
	logic [DT_W-1:0]     dt_r    [NUM_SLOTS];
	logic [MUL_W-1:0]    multi_r [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] key_on_r;

	// Slot writes outside the slot range are dropped
	assign wr_ok = wr_i && (wr_slot_i < NUM_SLOTS);

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			slot_cnt <= '0;
		else if (slot_cnt == SLOT_W'(NUM_SLOTS - 1))
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	// **************************************************
	// Global registers
	// **************************************************

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			fnum_hi_stage <= '0;
			block_stage   <= '0;
			acc_dis_r     <= 1'b0;
		end
		else if (wr_i)
		begin
			if (wr_op_i == OP_FNUM_HI)
			begin
				fnum_hi_stage <= wr_data_i[2:0];
				block_stage   <= wr_data_i[5:3];
			end
			if (wr_op_i == OP_TEST)
				acc_dis_r <= wr_data_i[3];
		end
	end

	// **************************************************
	// Per-slot registers
	// **************************************************

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				fnum_r[i]  <= '0;
				block_r[i] <= '0;
				dt_r[i]    <= '0;
				multi_r[i] <= '0;
			end
		end
		else if (wr_ok)
		begin
			case (wr_op_i)
				OP_FNUM_LO:
				begin
					fnum_r[wr_slot_i]  <= {fnum_hi_stage, wr_data_i};
					block_r[wr_slot_i] <= block_stage;
				end
				OP_DT_MUL:
				begin
					dt_r[wr_slot_i]    <= wr_data_i[6:4];
					multi_r[wr_slot_i] <= wr_data_i[3:0];
				end
				default: ;
			endcase
		end
	end

	// A key-on written while its slot is presented waits for the next round
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			key_on_r <= '0;
		else
		begin
			key_on_r[slot_cnt] <= 1'b0;
			if (wr_ok && wr_op_i == OP_KEY_ON)
				key_on_r[wr_slot_i] <= 1'b1;
		end
	end

	assign slot_o    = slot_cnt;
	assign fnum_o    = fnum_r[slot_cnt];
	assign block_o   = block_r[slot_cnt];
	assign dt_o      = dt_r[slot_cnt];
	assign multi_o   = multi_r[slot_cnt];
	assign key_on_o  = key_on_r[slot_cnt];
	assign acc_dis_o = acc_dis_r;

endmodule

`default_nettype wire

// ==== design/fm_detune.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fm_detune_table.svh"

module fm_detune
	import fm_pkg::*;
	#(
	parameter int SLOT_W = 5
	)
	(
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  logic [SLOT_W-1:0]  slot_i,
	input  logic [FNUM_W-1:0]  fnum_i,
	input  logic [BLOCK_W-1:0] block_i,
	input  logic [DT_W-1:0]    dt_i,
	input  logic [MUL_W-1:0]   multi_i,
	input  logic               restart_i,
	output logic [SLOT_W-1:0]  slot_o,
	output logic [FNUM_W-1:0]  fnum_o,
	output logic [BLOCK_W-1:0] block_o,
	output logic [MUL_W-1:0]   multi_o,
	output logic               restart_o,
	output logic [DTVAL_W-1:0] dt_val_o,
	output logic               dt_neg_o
	);

	localparam logic [DTVAL_W-1:0] DT_TABLE [0:31][0:3] = `FM_DETUNE_TABLE;

	logic               fnum_top;
	logic               round_bit;
	logic [BLOCK_W+1:0] key_code;

	// Key code is block, fnum MSB and a rounding bit from fnum 9..7
	assign fnum_top  = fnum_i[FNUM_W-1];
	assign round_bit = (fnum_top & |fnum_i[FNUM_W-2:FNUM_W-4])
		| (~fnum_top & &fnum_i[FNUM_W-2:FNUM_W-4]);
	assign key_code  = {block_i, fnum_top, round_bit};

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			slot_o    <= '0;
			restart_o <= 1'b0;
		end
		else
		begin
			slot_o    <= slot_i;
			restart_o <= restart_i;
		end
	end

	always_ff @(posedge MCLK)
	begin
		fnum_o   <= fnum_i;
		block_o  <= block_i;
		multi_o  <= multi_i;
		dt_val_o <= DT_TABLE[key_code][dt_i[1:0]];
		dt_neg_o <= dt_i[2];
	end

endmodule

`default_nettype wire

// ==== design/fm_pg.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_pg
	import fm_pkg::*;
	#(
	parameter int NUM_SLOTS = 24,
	localparam int SLOT_W = $clog2(NUM_SLOTS)
	)
	(
	input  logic               MCLK,
	input  logic               rst_n_i,
	input  logic [SLOT_W-1:0]  slot_i,
	input  logic [FNUM_W-1:0]  fnum_i,
	input  logic [BLOCK_W-1:0] block_i,
	input  logic [MUL_W-1:0]   multi_i,
	input  logic               restart_i,
	input  logic [DTVAL_W-1:0] dt_val_i,
	input  logic               dt_neg_i,
	input  logic               acc_dis_i,
	input  logic               dbg_load_i,
	input  logic [SLOT_W-1:0]  dbg_slot_i,
	output logic [OUT_W-1:0]   pg_out_o,
	output logic [SLOT_W-1:0]  pg_slot_o,
	output logic               pg_dbg_o
	);

	localparam int BASE_W = 17;
	localparam int DBG_W  = 10;

	logic [FNUM_W:0]     freq1;
	logic [FNUM_W+3:0]   freq2;
	logic [BASE_W-1:0]   freq3;

	logic                acc_dis_d;
	logic [SLOT_W-1:0]   slot_a;
	logic                reload_a;
	logic [BASE_W-1:0]   base_a;
	logic [DTVAL_W-1:0]  dt_val_a;
	logic                dt_neg_a;
	logic [MUL_W-1:0]    multi_a;

	logic [BASE_W-1:0]   dt_add;
	logic [BASE_W-1:0]   freq_dt;
	logic [PHASE_W-1:0]  freq_mul;

	logic [SLOT_W-1:0]   slot_b;
	logic                reload_b;
	logic [PHASE_W-1:0]  inc_b;

	logic [PHASE_W-1:0]  phase_mem [NUM_SLOTS];
	logic [PHASE_W-1:0]  phase_new;

	logic [DBG_W-1:0]    dbg_sr;

	// **************************************************
	// Stage A: block shift
	// **************************************************

	assign freq1 = {fnum_i, 1'b0};
	assign freq2 = {3'b000, freq1} << block_i[1:0];
	assign freq3 = block_i[2] ? BASE_W'({freq2, 1'b0}) : BASE_W'(freq2 >> 3);

	// Test bit arrives with stage R, one cycle ahead of the slot fields
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			acc_dis_d <= 1'b0;
			slot_a    <= '0;
			reload_a  <= 1'b0;
		end
		else
		begin
			acc_dis_d <= acc_dis_i;
			slot_a    <= slot_i;
			reload_a  <= restart_i | acc_dis_d;
		end
	end

	always_ff @(posedge MCLK)
	begin
		base_a   <= freq3;
		dt_val_a <= dt_val_i;
		dt_neg_a <= dt_neg_i;
		multi_a  <= multi_i;
	end

	// **************************************************
	// Stage B: detune and multiple
	// **************************************************

	assign dt_add  = BASE_W'(dt_val_a);
	assign freq_dt = dt_neg_a ? base_a - dt_add : base_a + dt_add;

	// Multiple 0 means one half
	assign freq_mul = (multi_a == '0) ? PHASE_W'(freq_dt >> 1)
		: PHASE_W'(freq_dt) * PHASE_W'(multi_a);

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			slot_b   <= '0;
			reload_b <= 1'b0;
		end
		else
		begin
			slot_b   <= slot_a;
			reload_b <= reload_a;
		end
	end

	always_ff @(posedge MCLK)
		inc_b <= freq_mul;

	// **************************************************
	// Stage C: accumulate into slot memory
	// **************************************************

	assign phase_new = reload_b ? inc_b : phase_mem[slot_b] + inc_b;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
				phase_mem[i] <= '0;
		end
		else
			phase_mem[slot_b] <= phase_new;
	end

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pg_out_o  <= '0;
			pg_slot_o <= '0;
		end
		else
		begin
			pg_out_o  <= phase_new[PHASE_W-1:PHASE_W-OUT_W];
			pg_slot_o <= slot_b;
		end
	end

	// Debug readout, memory already holds the phase shown on pg_out_o
	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
			dbg_sr <= '0;
		else if (dbg_load_i && pg_slot_o == dbg_slot_i)
			dbg_sr <= phase_mem[pg_slot_o][DBG_W-1:0];
		else
			dbg_sr <= {dbg_sr[DBG_W-2:0], 1'b0};
	end

	assign pg_dbg_o = dbg_sr[DBG_W-1];

endmodule

`default_nettype wire

// ==== design/fm_pg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_pg_top
	import fm_pkg::*;
	#(
	parameter int NUM_SLOTS = 24,
	localparam int SLOT_W = $clog2(NUM_SLOTS)
	)
	(
	input  logic              MCLK,
	input  logic              rst_n_i,
	input  logic              wr_i,
	input  pg_op_e            wr_op_i,
	input  logic [SLOT_W-1:0] wr_slot_i,
	input  logic [7:0]        wr_data_i,
	input  logic              dbg_load_i,
	input  logic [SLOT_W-1:0] dbg_slot_i,
	output logic [OUT_W-1:0]  pg_out_o,
	output logic [SLOT_W-1:0] pg_slot_o,
	output logic              pg_dbg_o
	);

	// Stage R, register outputs
	logic [SLOT_W-1:0]  r_slot;
	logic [FNUM_W-1:0]  r_fnum;
	logic [BLOCK_W-1:0] r_block;
	logic [DT_W-1:0]    r_dt;
	logic [MUL_W-1:0]   r_multi;
	logic               r_key_on;
	logic               r_acc_dis;

	// Detune stage outputs
	logic [SLOT_W-1:0]  d_slot;
	logic [FNUM_W-1:0]  d_fnum;
	logic [BLOCK_W-1:0] d_block;
	logic [MUL_W-1:0]   d_multi;
	logic               d_restart;
	logic [DTVAL_W-1:0] d_dt_val;
	logic               d_dt_neg;

	fm_pg_regs #(.NUM_SLOTS(NUM_SLOTS)) u_regs
		(
		.MCLK(MCLK), .rst_n_i(rst_n_i),
		.wr_i(wr_i), .wr_op_i(wr_op_i), .wr_slot_i(wr_slot_i), .wr_data_i(wr_data_i),
		.slot_o(r_slot), .fnum_o(r_fnum), .block_o(r_block), .dt_o(r_dt),
		.multi_o(r_multi), .key_on_o(r_key_on), .acc_dis_o(r_acc_dis)
		);

	fm_detune #(.SLOT_W(SLOT_W)) u_detune
		(
		.MCLK(MCLK), .rst_n_i(rst_n_i),
		.slot_i(r_slot), .fnum_i(r_fnum), .block_i(r_block), .dt_i(r_dt),
		.multi_i(r_multi), .restart_i(r_key_on),
		.slot_o(d_slot), .fnum_o(d_fnum), .block_o(d_block), .multi_o(d_multi),
		.restart_o(d_restart), .dt_val_o(d_dt_val), .dt_neg_o(d_dt_neg)
		);

	fm_pg #(.NUM_SLOTS(NUM_SLOTS)) u_pg
		(
		.MCLK(MCLK), .rst_n_i(rst_n_i),
		.slot_i(d_slot), .fnum_i(d_fnum), .block_i(d_block), .multi_i(d_multi),
		.restart_i(d_restart), .dt_val_i(d_dt_val), .dt_neg_i(d_dt_neg),
		.acc_dis_i(r_acc_dis), .dbg_load_i(dbg_load_i), .dbg_slot_i(dbg_slot_i),
		.pg_out_o(pg_out_o), .pg_slot_o(pg_slot_o), .pg_dbg_o(pg_dbg_o)
		);

endmodule

`default_nettype wire

// ==== verif/fm_pg_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fm_detune_table.svh"

module fm_pg_asserts
	import fm_pkg::*;
	#(
	parameter int NUM_SLOTS = 24,
	localparam int SLOT_W = $clog2(NUM_SLOTS)
	)
	(
	input logic              MCLK,
	input logic              rst_n_i,
	input logic              wr_i,
	input pg_op_e            wr_op_i,
	input logic [SLOT_W-1:0] wr_slot_i,
	input logic [7:0]        wr_data_i,
	input logic              dbg_load_i,
	input logic [SLOT_W-1:0] dbg_slot_i,
	input logic [OUT_W-1:0]  pg_out_o,
	input logic [SLOT_W-1:0] pg_slot_o,
	input logic              pg_dbg_o
	);

	localparam logic [DTVAL_W-1:0] DT_TABLE [0:31][0:3] = `FM_DETUNE_TABLE;
	// Output trails stage R by four cycles
	localparam int LAT = 4;

	// Shadow registers
	logic [FNUM_W-1:0]    fnum_m  [NUM_SLOTS];
	logic [BLOCK_W-1:0]   block_m [NUM_SLOTS];
	logic [DT_W-1:0]      dt_m    [NUM_SLOTS];
	logic [MUL_W-1:0]     mul_m   [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] key_m;
	logic [2:0]           fnum_hi_m;
	logic [BLOCK_W-1:0]   block_hi_m;
	logic                 acc_dis_m;

	// Reference phases and expected outputs
	logic [PHASE_W-1:0]   phase_m [NUM_SLOTS];
	logic [SLOT_W-1:0]    slot_m;
	logic [PHASE_W-1:0]   step_inc;
	logic [PHASE_W-1:0]   step_phase;
	logic [SLOT_W-1:0]    slot_q  [LAT];
	logic [PHASE_W-1:0]   phase_q [LAT];
	logic [9:0]           dbg_m;

	int slot_err = 0;
	int phase_err = 0;
	int dbg_err = 0;

	function automatic logic [PHASE_W-1:0] phase_step(input logic [FNUM_W-1:0] fnum,
		input logic [BLOCK_W-1:0] blk, input logic [DT_W-1:0] dt, input logic [MUL_W-1:0] mul);
		logic [31:0] base;
		logic        rnd;
		logic [4:0]  kc;
		logic [16:0] det;
		logic [31:0] prod;
		base = 32'(fnum) << (blk[1:0] + 1);
		base = blk[2] ? (base << 1) : (base >> 3);
		rnd  = fnum[10] ? |fnum[9:7] : &fnum[9:7];
		kc   = {blk, fnum[10], rnd};
		if (dt[2])
			det = 17'(base) - 17'(DT_TABLE[kc][dt[1:0]]);
		else
			det = 17'(base) + 17'(DT_TABLE[kc][dt[1:0]]);
		// Multiple 0 is one half
		prod = (mul == '0) ? 32'(det >> 1) : 32'(det) * 32'(mul);
		return prod[PHASE_W-1:0];
	endfunction

	assign step_inc   = phase_step(fnum_m[slot_m], block_m[slot_m], dt_m[slot_m], mul_m[slot_m]);
	assign step_phase = (key_m[slot_m] || acc_dis_m) ? step_inc : phase_m[slot_m] + step_inc;

	always_ff @(posedge MCLK or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
			begin
				fnum_m[i]  <= '0;
				block_m[i] <= '0;
				dt_m[i]    <= '0;
				mul_m[i]   <= '0;
				phase_m[i] <= '0;
			end
			for (int i = 0; i < LAT; i++)
			begin
				slot_q[i]  <= '0;
				phase_q[i] <= '0;
			end
			key_m      <= '0;
			fnum_hi_m  <= '0;
			block_hi_m <= '0;
			acc_dis_m  <= 1'b0;
			slot_m     <= '0;
			dbg_m      <= '0;
		end
		else
		begin
			// Stage R of the model slot
			phase_m[slot_m] <= step_phase;
			key_m[slot_m]   <= 1'b0;
			slot_q[0]       <= slot_m;
			phase_q[0]      <= step_phase;
			for (int i = 1; i < LAT; i++)
			begin
				slot_q[i]  <= slot_q[i-1];
				phase_q[i] <= phase_q[i-1];
			end
			slot_m <= (slot_m == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot_m + 1'b1;

			if (wr_i)
			begin
				case (wr_op_i)
					OP_FNUM_HI:
					begin
						fnum_hi_m  <= wr_data_i[2:0];
						block_hi_m <= wr_data_i[5:3];
					end
					OP_FNUM_LO:
					begin
						fnum_m[wr_slot_i]  <= {fnum_hi_m, wr_data_i};
						block_m[wr_slot_i] <= block_hi_m;
					end
					OP_DT_MUL:
					begin
						dt_m[wr_slot_i]  <= wr_data_i[6:4];
						mul_m[wr_slot_i] <= wr_data_i[3:0];
					end
					OP_TEST:   acc_dis_m <= wr_data_i[3];
					OP_KEY_ON: key_m[wr_slot_i] <= 1'b1;
					default: ;
				endcase
			end

			if (dbg_load_i && slot_q[LAT-1] == dbg_slot_i)
				dbg_m <= phase_q[LAT-1][9:0];
			else
				dbg_m <= {dbg_m[8:0], 1'b0};
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	slot_order: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		pg_slot_o == slot_q[LAT-1])
	else
	begin
		slot_err++;
		$error("FAILED pg_slot_o got %h expected %h", $sampled(pg_slot_o),
			$sampled(slot_q[LAT-1]));
	end

	phase_out: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		pg_out_o == phase_q[LAT-1][PHASE_W-1:PHASE_W-OUT_W])
	else
	begin
		phase_err++;
		$error("FAILED pg_out_o got %h expected %h", $sampled(pg_out_o),
			$sampled(phase_q[LAT-1][PHASE_W-1:PHASE_W-OUT_W]));
	end

	dbg_bit: assert property (@(posedge MCLK) disable iff (!rst_n_i) pg_dbg_o == dbg_m[9])
	else
	begin
		dbg_err++;
		$error("FAILED pg_dbg_o got %h expected %h", $sampled(pg_dbg_o), $sampled(dbg_m[9]));
	end

endmodule

`default_nettype wire

// ==== verif/fm_pg_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_pg_tb
	import fm_pkg::*;
	();

	localparam int NUM_SLOTS = 24;
	localparam int SLOT_W = $clog2(NUM_SLOTS);

	logic              MCLK = 1'b0;
	logic              rst_n_i;
	logic              wr_i;
	pg_op_e            wr_op_i;
	logic [SLOT_W-1:0] wr_slot_i;
	logic [7:0]        wr_data_i;
	logic              dbg_load_i;
	logic [SLOT_W-1:0] dbg_slot_i;
	logic [OUT_W-1:0]  pg_out_o;
	logic [SLOT_W-1:0] pg_slot_o;
	logic              pg_dbg_o;

	int seed;
	int timeouts;
	int errors;
	int cycles = 0;

	fm_pg_top #(.NUM_SLOTS(NUM_SLOTS)) DUT
		(
		.MCLK(MCLK), .rst_n_i(rst_n_i),
		.wr_i(wr_i), .wr_op_i(wr_op_i), .wr_slot_i(wr_slot_i), .wr_data_i(wr_data_i),
		.dbg_load_i(dbg_load_i), .dbg_slot_i(dbg_slot_i),
		.pg_out_o(pg_out_o), .pg_slot_o(pg_slot_o), .pg_dbg_o(pg_dbg_o)
		);

	bind fm_pg_top fm_pg_asserts #(.NUM_SLOTS(NUM_SLOTS)) u_asserts
		(
		.MCLK(MCLK), .rst_n_i(rst_n_i),
		.wr_i(wr_i), .wr_op_i(wr_op_i), .wr_slot_i(wr_slot_i), .wr_data_i(wr_data_i),
		.dbg_load_i(dbg_load_i), .dbg_slot_i(dbg_slot_i),
		.pg_out_o(pg_out_o), .pg_slot_o(pg_slot_o), .pg_dbg_o(pg_dbg_o)
		);

	always #4 MCLK = ~MCLK;

	always @(posedge MCLK)
		if (rst_n_i)
			cycles <= cycles + 1;

	// **************************************************
	// Register writes
	// **************************************************

	task automatic write_reg(input pg_op_e op, input int slot, input logic [7:0] data);
		@(posedge MCLK);
		wr_i      <= 1'b1;
		wr_op_i   <= op;
		wr_slot_i <= SLOT_W'(slot);
		wr_data_i <= data;
		@(posedge MCLK);
		wr_i <= 1'b0;
	endtask

	task automatic set_freq(input int slot, input logic [10:0] fnum, input logic [2:0] blk);
		write_reg(OP_FNUM_HI, slot, {2'b00, blk, fnum[10:8]});
		write_reg(OP_FNUM_LO, slot, fnum[7:0]);
	endtask

	task automatic set_dt_mul(input int slot, input logic [2:0] dt, input logic [3:0] mul);
		write_reg(OP_DT_MUL, slot, {1'b0, dt, mul});
	endtask

	task automatic idle_rounds(input int n);
		repeat (n * NUM_SLOTS) @(posedge MCLK);
	endtask

	// Every block value appears, and every fifth slot halves
	task automatic load_random_voices();
		logic [10:0] fnum;
		logic [3:0]  mul;
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			fnum = 11'($random(seed));
			mul  = (i % 5 == 0) ? 4'd0 : 4'($random(seed));
			set_freq(i, fnum, 3'(i % 8));
			set_dt_mul(i, 3'd0, mul);
		end
	endtask

	// Both rounding cases with fnum bit 10 high and low, all detune codes
	task automatic load_detune_voices();
		logic [10:0] fnums [4];
		fnums = '{11'h400, 11'h780, 11'h380, 11'h1ff};
		for (int i = 0; i < 16; i++)
		begin
			set_freq(i, fnums[i % 4], 3'(i / 2));
			set_dt_mul(i, 3'(i % 8), 4'(1 + i % 3));
		end
	endtask

	task automatic read_debug(input int slot);
		int waited;
		waited = 0;
		@(posedge MCLK);
		dbg_slot_i <= SLOT_W'(slot);
		dbg_load_i <= 1'b1;
		@(negedge MCLK);
		while (pg_slot_o != SLOT_W'(slot) && waited < 2 * NUM_SLOTS)
		begin
			@(negedge MCLK);
			waited++;
		end
		if (waited >= 2 * NUM_SLOTS)
		begin
			$display("Timeout while waiting for pg_slot_o to reach slot %0d", slot);
			timeouts++;
		end
		@(posedge MCLK);
		dbg_load_i <= 1'b0;
		// Ten data bits, then zeros
		repeat (14) @(posedge MCLK);
	endtask

	initial
	begin
		seed       = 87;
		timeouts   = 0;
		rst_n_i    = 1'b0;
		wr_i       = 1'b0;
		wr_op_i    = OP_FNUM_HI;
		wr_slot_i  = '0;
		wr_data_i  = '0;
		dbg_load_i = 1'b0;
		dbg_slot_i = '0;
		repeat (8) @(posedge MCLK);
		rst_n_i <= 1'b1;
		idle_rounds(2);

		load_random_voices();
		idle_rounds(4);

		load_detune_voices();
		idle_rounds(3);

		write_reg(OP_KEY_ON, 5, 8'h00);
		write_reg(OP_KEY_ON, 17, 8'h00);
		idle_rounds(2);

		write_reg(OP_TEST, 0, 8'h08);
		idle_rounds(3);
		write_reg(OP_TEST, 0, 8'h00);
		idle_rounds(2);

		read_debug(3);
		read_debug(10);
		read_debug(0);
		read_debug(NUM_SLOTS - 1);
		idle_rounds(1);

		errors = DUT.u_asserts.slot_err + DUT.u_asserts.phase_err + DUT.u_asserts.dbg_err
			+ timeouts;
		$display("Cycles %0d, slot errors %0d, phase errors %0d, debug errors %0d, timeouts %0d",
			cycles, DUT.u_asserts.slot_err, DUT.u_asserts.phase_err, DUT.u_asserts.dbg_err,
			timeouts);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/fm_pkg.sv
design/fm_pg_regs.sv
design/fm_detune.sv
design/fm_pg.sv
design/fm_pg_top.sv
verif/fm_pg_asserts.sv
verif/fm_pg_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fm_pg testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fm_pg_tb -o fm_pg_sim \
	&& ./obj_dir/fm_pg_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Simulation did not run to completion"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" && exit 0 \
	|| { echo "FAIL"; exit 1; }
